/* src.f */
+incdir+verification
design/lut_pkg.sv
design/mul_link_if.sv
design/coeff_rom.sv
design/partial_product_gen.sv
design/compressor_stage.sv
design/final_adder.sv
design/rom_lut.sv
verification/tb_rom_lut.sv

/* verification/tb_util.svh */
/* testbench helpers
   LFSR stimulus source, reference product and result compare tasks */

    // 16-bit Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // one LFSR step per bit taken, lsb first
    task automatic take_bits(
        inout  logic [15:0] state,
        input  int          n,
        output logic [7:0]  bits
    );
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = state[0];
            state   = lfsr_step(state);
        end
    endtask

    // selector times table coefficient, zero-extended to the output width
    function automatic logic [lut_pkg::OUT_W-1:0] ref_product(
        input logic [lut_pkg::SEL_W-1:0]   sel,
        input logic [lut_pkg::TABLE_W-1:0] tbl
    );
        logic [lut_pkg::PROD_W-1:0] a;
        logic [lut_pkg::PROD_W-1:0] b;
        logic [lut_pkg::PROD_W-1:0] prod;
        logic [lut_pkg::OUT_W-1:0]  wide;
        a    = sel;
        b    = lut_pkg::COEFF_TABLE[tbl];
        prod = a * b;
        wide = prod;
        return wide;
    endfunction

    task automatic check_value(
        input logic [lut_pkg::OUT_W-1:0] got,
        input logic [lut_pkg::OUT_W-1:0] exp
    );
        if (got !== exp) begin
            abort_run($sformatf("FAIL out_value got %h expected %h", got, exp));
        end
    endtask

    task automatic check_tag(
        input logic [lut_pkg::TAG_W-1:0] got,
        input logic [lut_pkg::TAG_W-1:0] exp
    );
        if (got !== exp) begin
            abort_run($sformatf("FAIL out_tag got %h expected %h", got, exp));
        end
    endtask

/* verification/tb_rom_lut.sv */
/* testbench for the lookup-and-scale unit
   checks results, ordering, latency and stall hold against a reference model */
`default_nettype none

module tb_rom_lut;

    localparam int CLK_PERIOD      = 100;
    localparam int RAND_COUNT      = 300;
    localparam int LAT_COUNT       = 16;
    localparam int NUM_REQUESTS    = 64 + RAND_COUNT + LAT_COUNT;
    localparam int WATCHDOG_CYCLES = (NUM_REQUESTS + lut_pkg::PIPE_DEPTH) * 20;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic                        in_ready;
    logic [lut_pkg::SEL_W-1:0]   in_sel;
    logic [lut_pkg::TABLE_W-1:0] in_table;
    logic [lut_pkg::TAG_W-1:0]   in_tag;
    logic                        out_valid;
    logic                        out_ready;
    logic [lut_pkg::OUT_W-1:0]   out_value;
    logic [lut_pkg::TAG_W-1:0]   out_tag;

    logic [15:0] stim_state;
    logic [15:0] ready_state;
    logic        random_ready;
    logic        latency_mode;
    int          cycle;

    // scoreboard with one entry per accepted request
    logic [lut_pkg::OUT_W-1:0] exp_value_q[$];
    logic [lut_pkg::TAG_W-1:0] exp_tag_q[$];
    int                        accept_q[$];

    rom_lut DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_sel    (in_sel),
        .in_table  (in_table),
        .in_tag    (in_tag),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_value (out_value),
        .out_tag   (out_tag)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    `include "tb_util.svh"

    // called and returns 10 after a rising edge
    task automatic send_request(
        input logic [lut_pkg::SEL_W-1:0]   sel,
        input logic [lut_pkg::TABLE_W-1:0] tbl,
        input logic [lut_pkg::TAG_W-1:0]   tag
    );
        in_valid = 1'b1;
        in_sel   = sel;
        in_table = tbl;
        in_tag   = tag;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic drain();
        in_valid     = 1'b0;
        random_ready = 1'b0;
        while (exp_value_q.size() != 0) begin
            @(posedge clk);
            #10;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle = cycle + 1;
        end
    end

    // out_ready gaps from their own LFSR
    initial begin
        logic [7:0] bits;
        logic       use_random;
        out_ready   = 1'b1;
        ready_state = 16'd31999;
        forever begin
            @(posedge clk);
            use_random = random_ready;
            #10;
            if (use_random) begin
                take_bits(ready_state, 1, bits);
                out_ready = bits[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // monitor and compare at the falling edge where handshakes are settled
    initial begin
        int                        acc;
        logic                      stall_pending;
        logic [lut_pkg::OUT_W-1:0] held_value;
        logic [lut_pkg::TAG_W-1:0] held_tag;
        logic [lut_pkg::OUT_W-1:0] exp_value;
        logic [lut_pkg::TAG_W-1:0] exp_tag;
        stall_pending = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (in_valid && in_ready) begin
                    exp_value_q.push_back(ref_product(in_sel, in_table));
                    exp_tag_q.push_back(in_tag);
                    accept_q.push_back(cycle);
                end
                if (latency_mode && !in_ready) begin
                    abort_run("in_ready dropped during back-to-back requests");
                end
                if (stall_pending) begin
                    if (!out_valid) begin
                        abort_run("out_valid dropped while the output was stalled");
                    end
                    check_value(out_value, held_value);
                    check_tag(out_tag, held_tag);
                end
                stall_pending = out_valid && !out_ready;
                held_value    = out_value;
                held_tag      = out_tag;
                if (out_valid && out_ready) begin
                    if (exp_value_q.size() == 0) begin
                        abort_run("result delivered with no pending request");
                    end
                    exp_value = exp_value_q.pop_front();
                    exp_tag   = exp_tag_q.pop_front();
                    acc       = accept_q.pop_front();
                    check_value(out_value, exp_value);
                    check_tag(out_tag, exp_tag);
                    if (latency_mode && (cycle - acc) != lut_pkg::PIPE_DEPTH) begin
                        abort_run($sformatf("result took %0d cycles instead of %0d",
                                            cycle - acc, lut_pkg::PIPE_DEPTH));
                    end
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog timeout, pipeline stopped returning results");
    end

    initial begin
        logic [7:0]                  bits;
        logic [lut_pkg::SEL_W-1:0]   sel;
        logic [lut_pkg::TABLE_W-1:0] tbl;
        int                          n;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_sel       = '0;
        in_table     = '0;
        in_tag       = '0;
        stim_state   = 16'd31999;
        random_ready = 1'b0;
        latency_mode = 1'b0;

        @(posedge clk);
        repeat (2) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                abort_run("out_valid high during reset");
            end
            @(posedge clk);
        end
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b0) begin
            abort_run("out_valid or in_ready high in the first cycle after reset");
        end
        @(negedge clk);
        if (in_ready !== 1'b1) begin
            abort_run("in_ready did not rise after the first cycle out of reset");
        end
        @(posedge clk);
        #10;

        // every selector under every table entry
        for (int t = 0; t < lut_pkg::NUM_TABLES; t++) begin
            for (int s = 0; s < 16; s++) begin
                n = t * 16 + s;
                send_request(s[lut_pkg::SEL_W-1:0], t[lut_pkg::TABLE_W-1:0],
                             n[lut_pkg::TAG_W-1:0]);
            end
        end

        // random gaps on both sides
        random_ready = 1'b1;
        for (int i = 0; i < RAND_COUNT; i++) begin
            take_bits(stim_state, 2, bits);
            idle(bits);
            take_bits(stim_state, lut_pkg::SEL_W, bits);
            sel = bits[lut_pkg::SEL_W-1:0];
            take_bits(stim_state, lut_pkg::TABLE_W, bits);
            tbl = bits[lut_pkg::TABLE_W-1:0];
            send_request(sel, tbl, i[lut_pkg::TAG_W-1:0]);
        end
        drain();
        idle(2);

        // back-to-back with the output always ready
        latency_mode = 1'b1;
        for (int i = 0; i < LAT_COUNT; i++) begin
            take_bits(stim_state, lut_pkg::SEL_W, bits);
            sel = bits[lut_pkg::SEL_W-1:0];
            take_bits(stim_state, lut_pkg::TABLE_W, bits);
            tbl = bits[lut_pkg::TABLE_W-1:0];
            send_request(sel, tbl, i[lut_pkg::TAG_W-1:0]);
        end
        drain();
        latency_mode = 1'b0;

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* design/rom_lut.sv */
/* coefficient lookup-and-scale unit
   four-stage valid/ready pipeline multiplying a selector by a table coefficient */
`default_nettype none

module rom_lut (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [lut_pkg::SEL_W-1:0]   in_sel,
    input  logic [lut_pkg::TABLE_W-1:0] in_table,
    input  logic [lut_pkg::TAG_W-1:0]   in_tag,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [lut_pkg::OUT_W-1:0]   out_value,
    output logic [lut_pkg::TAG_W-1:0]   out_tag
);

    // selector and coefficient
    mul_link_if #(.DATA_W(2*lut_pkg::SEL_W)) l0 ();
    // four partial-product rows
    mul_link_if #(.DATA_W(4*lut_pkg::SEL_W)) l1 ();
    // sum and carry words
    mul_link_if #(.DATA_W(2*lut_pkg::PROD_W)) l2 ();

    coeff_rom u_coeff_rom (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_sel   (in_sel),
        .in_table (in_table),
        .in_tag   (in_tag),
        .out      (l0.src)
    );

    partial_product_gen u_pp_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (l0.dst),
        .out   (l1.src)
    );

    compressor_stage u_compressor (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (l1.dst),
        .out   (l2.src)
    );

    final_adder u_final_adder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (l2.dst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_value (out_value),
        .out_tag   (out_tag)
    );

endmodule

`default_nettype wire

/* design/final_adder.sv */
/* final carry-propagate stage
   adds sum and carry words and registers the widened product with its tag */
`default_nettype none

module final_adder (
    input  logic                      clk,
    input  logic                      rst_n,
    mul_link_if.dst                   in,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [lut_pkg::OUT_W-1:0] out_value,
    output logic [lut_pkg::TAG_W-1:0] out_tag
);

    logic                       in_xfer;
    logic [lut_pkg::PROD_W-1:0] product;

    assign in.ready = !out_valid || out_ready;
    assign in_xfer  = in.valid && in.ready;

    // product fits in PROD_W, no carry out
    assign product = in.data[2*lut_pkg::PROD_W-1:lut_pkg::PROD_W]
                   + in.data[lut_pkg::PROD_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_xfer) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            out_value <= lut_pkg::OUT_W'(product);
            out_tag   <= in.tag;
        end
    end

    assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid)
    ) else $error("final_adder: out_valid unknown");

endmodule

`default_nettype wire

/* design/compressor_stage.sv */
/* carry-save compression stage
   two full-adder rows reduce the shifted partial products to sum and carry */
`default_nettype none

module compressor_stage (
    input  logic    clk,
    input  logic    rst_n,
    mul_link_if.dst in,
    mul_link_if.src out
);

    localparam int PW = lut_pkg::PROD_W;
    localparam int SW = lut_pkg::SEL_W;

    logic          valid_q;
    logic          in_xfer;
    logic [PW-1:0] r0;
    logic [PW-1:0] r1;
    logic [PW-1:0] r2;
    logic [PW-1:0] r3;
    logic [PW-1:0] s1;
    logic [PW-1:0] c1;
    logic [PW-1:0] s2;
    logic [PW-1:0] c2;
    logic [4*SW-1:0] rows_q;

    assign in.ready  = !valid_q || out.ready;
    assign in_xfer   = in.valid && in.ready;
    assign out.valid = valid_q;

    // align each row to its weight
    assign r0 = PW'(in.data[SW-1:0]);
    assign r1 = PW'(in.data[2*SW-1:SW]) << 1;
    assign r2 = PW'(in.data[3*SW-1:2*SW]) << 2;
    assign r3 = PW'(in.data[4*SW-1:3*SW]) << 3;

    // first full-adder row, rows 0 to 2
    assign s1 = r0 ^ r1 ^ r2;
    assign c1 = ((r0 & r1) | (r0 & r2) | (r1 & r2)) << 1;

    // second row folds in row 3
    assign s2 = s1 ^ c1 ^ r3;
    assign c2 = ((s1 & c1) | (s1 & r3) | (c1 & r3)) << 1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_xfer) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            out.data <= {s2, c2};
            out.tag  <= in.tag;
            rows_q   <= in.data;
        end
    end

    // weighted sum of the four registered rows
    function automatic logic [PW:0] row_value(input logic [4*SW-1:0] rows);
        logic [PW:0] acc;
        acc = '0;
        for (int i = 0; i < 4; i++) begin
            acc = acc + ((PW+1)'(rows[i*SW +: SW]) << i);
        end
        return acc;
    endfunction

    // the redundant form handed on must still equal the product
    assert property (
        @(posedge clk) disable iff (!rst_n)
        out.valid && out.ready |->
            ((PW+1)'(out.data[2*PW-1:PW]) + (PW+1)'(out.data[PW-1:0]))
                == row_value(rows_q)
    ) else $error("compressor_stage: sum and carry do not match rows");

endmodule

`default_nettype wire

/* design/partial_product_gen.sv */
/* partial product stage
   gates the multiplier with each multiplicand bit and registers four rows */
`default_nettype none

module partial_product_gen (
    input  logic    clk,
    input  logic    rst_n,
    mul_link_if.dst in,
    mul_link_if.src out
);

    logic                      valid_q;
    logic                      in_xfer;
    logic [lut_pkg::SEL_W-1:0] mplier;
    logic [lut_pkg::SEL_W-1:0] mcand;
    logic [lut_pkg::SEL_W-1:0] pp0;
    logic [lut_pkg::SEL_W-1:0] pp1;
    logic [lut_pkg::SEL_W-1:0] pp2;
    logic [lut_pkg::SEL_W-1:0] pp3;

    assign in.ready  = !valid_q || out.ready;
    assign in_xfer   = in.valid && in.ready;
    assign out.valid = valid_q;

    assign mplier = in.data[2*lut_pkg::SEL_W-1:lut_pkg::SEL_W];
    assign mcand  = in.data[lut_pkg::SEL_W-1:0];

    // row i carries weight 2**i, shift is applied in the compressor
    assign pp0 = mplier & {lut_pkg::SEL_W{mcand[0]}};
    assign pp1 = mplier & {lut_pkg::SEL_W{mcand[1]}};
    assign pp2 = mplier & {lut_pkg::SEL_W{mcand[2]}};
    assign pp3 = mplier & {lut_pkg::SEL_W{mcand[3]}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_xfer) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            out.data <= {pp3, pp2, pp1, pp0};
            out.tag  <= in.tag;
        end
    end

endmodule

`default_nettype wire

/* design/coeff_rom.sv */
/* coefficient lookup stage
   accepts requests and registers the selector with its table coefficient */
`default_nettype none

module coeff_rom (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [lut_pkg::SEL_W-1:0]   in_sel,
    input  logic [lut_pkg::TABLE_W-1:0] in_table,
    input  logic [lut_pkg::TAG_W-1:0]   in_tag,
    mul_link_if.src                     out
);

    logic                      accept_en;
    logic                      valid_q;
    logic                      in_xfer;
    logic [lut_pkg::SEL_W-1:0] coeff;

    assign coeff    = lut_pkg::COEFF_TABLE[in_table];
    assign in_ready = accept_en && (!valid_q || out.ready);
    assign in_xfer  = in_valid && in_ready;
    assign out.valid = valid_q;

    // no requests taken until one cycle after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accept_en <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            accept_en <= 1'b1;
            if (in_xfer) begin
                valid_q <= 1'b1;
            end else if (out.ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    // multiplier in the upper half, multiplicand in the lower
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            out.data <= {in_sel, coeff};
            out.tag  <= in_tag;
        end
    end

    // a stalled item must not change under the downstream stages
    assert property (
        @(posedge clk) disable iff (!rst_n)
        out.valid && !out.ready |=> $stable(out.data) && $stable(out.tag)
    ) else $error("coeff_rom: payload changed while stalled");

endmodule

`default_nettype wire

/* design/mul_link_if.sv */
/* valid/ready link between multiplier pipeline stages
   carries a payload word and the request tag */
`default_nettype none

interface mul_link_if #(
    parameter int DATA_W = 8
) ();

    logic                      valid;
    logic                      ready;
    logic [DATA_W-1:0]         data;
    logic [lut_pkg::TAG_W-1:0] tag;

    // upstream side
    modport src (
        output valid,
        output data,
        output tag,
        input  ready
    );

    // downstream side
    modport dst (
        input  valid,
        input  data,
        input  tag,
        output ready
    );

endinterface

`default_nettype wire

/* design/lut_pkg.sv */
/* lookup-and-scale shared definitions
   widths, pipeline depth and the coefficient table */
`default_nettype none

package lut_pkg;

    // request fields
    localparam int SEL_W   = 4;
    localparam int TABLE_W = 2;
    localparam int TAG_W   = 4;

    // result widths
    localparam int PROD_W = 8;
    localparam int OUT_W  = 24;

    localparam int NUM_TABLES = 4;

    // registered stages from request to result
    localparam int PIPE_DEPTH = 4;

    // index 0 is the unit coefficient
    localparam logic [NUM_TABLES-1:0][SEL_W-1:0] COEFF_TABLE = {
        4'd15,
        4'd10,
        4'd3,
        4'd1
    };

endpackage

`default_nettype wire
